// ==== src/adc_pkg.sv ====
package adc_pkg;

  // Converter resolution in bits
  localparam int ADC_BITS = 14;

  // Falling edges seen with chip select low in one frame
  // Two leading zeros, then the data bits MSB first
  localparam int FRAME_EDGES = ADC_BITS + 2;

  // Straight-binary code that sits at zero volts
  localparam int ADC_MIDSCALE = 1 << (ADC_BITS - 1);

  // Limits of the signed sample range
  localparam int SAMPLE_MAX = (1 << (ADC_BITS - 1)) - 1;
  localparam int SAMPLE_MIN = -(1 << (ADC_BITS - 1));

  // Raw unsigned conversion code as shifted in from the pins
  typedef logic [ADC_BITS-1:0] adc_code_t;

  // Signed, offset-corrected sample
  typedef logic signed [ADC_BITS-1:0] adc_sample_t;

endpackage

// ==== src/adc_stream_if.sv ====
`timescale 1ns/1ps

// Sample pair handshake between pipeline stages
// Transfer on an edge with valid and ready both high
interface adc_stream_if #(
  parameter type SAMPLE_T = adc_pkg::adc_code_t
) ();

  logic    valid;
  logic    ready;
  // Channel A and channel B of one simultaneous conversion
  SAMPLE_T sample_a;
  SAMPLE_T sample_b;

  // Producer side
  modport source (
    output valid,
    output sample_a,
    output sample_b,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  sample_a,
    input  sample_b,
    output ready
  );

endinterface

// ==== src/conv_pacer.sv ====
`timescale 1ns/1ps

module conv_pacer #(
  // Minimum edges from one request to the next
  parameter int CONV_PERIOD = 24
) (
  // Serial clock, whole design works on its falling edge
  input  logic i_if_sclk,
  input  logic i_rst,
  // Capture stage is idle with no result pending
  input  logic i_idle,
  // One-edge conversion request
  output logic o_conv_req
);

  localparam int CNT_W = $clog2(CONV_PERIOD + 1);

  logic [CNT_W-1:0] r_cnt;
  logic             at_period;

  // Counter stops at the period and waits there
  assign at_period = (r_cnt >= CNT_W'(CONV_PERIOD));

  // Request only when the capture engine can take it
  // Busy or holding stage stretches the interval instead of dropping data
  assign o_conv_req = at_period && i_idle;

  always_ff @(negedge i_if_sclk) begin
    if (i_rst) begin
      r_cnt <= '0;
    end else if (o_conv_req) begin
      // Request edge counts as the first edge of the next interval
      r_cnt <= CNT_W'(1);
    end else if (!at_period) begin
      r_cnt <= r_cnt + CNT_W'(1);
    end
  end

endmodule

// ==== src/ad7357_capture.sv ====
`timescale 1ns/1ps

module ad7357_capture (
  // Serial clock, ADC drives data on falling edges
  input  logic        i_if_sclk,
  input  logic        i_rst,
  // Start of conversion, sampled only in IDLE
  input  logic        i_conv_req,
  // ADC serial pins
  input  logic        i_if_sdata_a,
  input  logic        i_if_sdata_b,
  output logic        o_if_cs_n,
  // No frame running and no result waiting
  output logic        o_idle,
  // Raw code pair toward the corrector
  adc_stream_if.source o_raw
);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    HOLD
  } state_t;

  state_t             r_state;
  logic               r_if_cs_n;
  adc_pkg::adc_code_t r_data_a;
  adc_pkg::adc_code_t r_data_b;
  // Marker overflow, bit 1 set means the frame ends on this edge
  logic [1:0]         r_ovf;
  logic               start;

  assign start  = (r_state == IDLE) && i_conv_req;
  assign o_idle = (r_state == IDLE);

  assign o_if_cs_n = r_if_cs_n;

  // Result sits on the stream for the whole HOLD state
  assign o_raw.valid    = (r_state == HOLD);
  assign o_raw.sample_a = r_data_a;
  assign o_raw.sample_b = r_data_b;

  // Frame control
  always_ff @(negedge i_if_sclk) begin
    if (i_rst) begin
      r_state   <= IDLE;
      r_if_cs_n <= 1'b1;
    end else begin
      case (r_state)
        IDLE: begin
          // Chip select drops on the request edge
          if (i_conv_req) begin
            r_state   <= SHIFT;
            r_if_cs_n <= 1'b0;
          end
        end
        SHIFT: begin
          // Marker has passed both overflow bits, so this is the 16th edge
          if (r_ovf[1]) begin
            r_state   <= HOLD;
            r_if_cs_n <= 1'b1;
          end
        end
        HOLD: begin
          // Stall here until the corrector takes the pair
          if (o_raw.ready) begin
            r_state <= IDLE;
          end
        end
        default: begin
          r_state   <= IDLE;
          r_if_cs_n <= 1'b1;
        end
      endcase
    end
  end

  // Shift registers
  always_ff @(negedge i_if_sclk) begin
    if (start) begin
      // Single marker bit in the LSB of channel A counts the frame
      r_data_a <= adc_pkg::adc_code_t'(1);
      r_data_b <= '0;
      r_ovf    <= 2'b00;
    end else if (r_state == SHIFT) begin
      // MSB first, only the last 14 bits survive
      r_ovf    <= {r_ovf[0], r_data_a[adc_pkg::ADC_BITS-1]};
      r_data_a <= {r_data_a[adc_pkg::ADC_BITS-2:0], i_if_sdata_a};
      r_data_b <= {r_data_b[adc_pkg::ADC_BITS-2:0], i_if_sdata_b};
    end
  end

endmodule

// ==== src/offset_correct.sv ====
`timescale 1ns/1ps

module offset_correct (
  input  logic                 i_if_sclk,
  input  logic                 i_rst,
  // Per-channel offset, subtracted after centering
  input  adc_pkg::adc_sample_t i_offset_a,
  input  adc_pkg::adc_sample_t i_offset_b,
  // Raw straight-binary codes
  adc_stream_if.sink           i_raw,
  // Signed corrected samples
  adc_stream_if.source         o_corr
);

  // Two guard bits hold the full range of code minus midscale minus offset
  localparam int CORR_W = adc_pkg::ADC_BITS + 2;

  logic                 r_full;
  adc_pkg::adc_sample_t r_corr_a;
  adc_pkg::adc_sample_t r_corr_b;
  logic                 take;

  // Center one code, remove its offset and clip to the signed range
  function automatic adc_pkg::adc_sample_t correct(
    input adc_pkg::adc_code_t   code,
    input adc_pkg::adc_sample_t offset
  );
    logic signed [CORR_W-1:0] centered;
    logic signed [CORR_W-1:0] diff;
    centered = $signed({{(CORR_W - adc_pkg::ADC_BITS){1'b0}}, code})
               - CORR_W'(adc_pkg::ADC_MIDSCALE);
    // Offset is sign extended by the cast
    diff = centered - CORR_W'(offset);
    if (diff > CORR_W'(adc_pkg::SAMPLE_MAX)) begin
      correct = adc_pkg::adc_sample_t'(adc_pkg::SAMPLE_MAX);
    end else if (diff < CORR_W'(adc_pkg::SAMPLE_MIN)) begin
      correct = adc_pkg::adc_sample_t'(adc_pkg::SAMPLE_MIN);
    end else begin
      correct = diff[adc_pkg::ADC_BITS-1:0];
    end
  endfunction

  // Accept when empty or when the held pair leaves on this edge
  assign i_raw.ready = !r_full || o_corr.ready;
  assign take        = i_raw.valid && i_raw.ready;

  assign o_corr.valid    = r_full;
  assign o_corr.sample_a = r_corr_a;
  assign o_corr.sample_b = r_corr_b;

  // Occupancy of the single entry
  always_ff @(negedge i_if_sclk) begin
    if (i_rst) begin
      r_full <= 1'b0;
    end else if (take) begin
      r_full <= 1'b1;
    end else if (o_corr.ready) begin
      r_full <= 1'b0;
    end
  end

  // Corrected pair, loaded on every input transfer
  always_ff @(negedge i_if_sclk) begin
    if (take) begin
      r_corr_a <= correct(i_raw.sample_a, i_offset_a);
      r_corr_b <= correct(i_raw.sample_b, i_offset_b);
    end
  end

endmodule

// ==== src/box_decimator.sv ====
`timescale 1ns/1ps

module box_decimator #(
  // Pairs averaged per output, power of two
  parameter int DECIM = 4
) (
  input  logic                 i_if_sclk,
  input  logic                 i_rst,
  // Downstream ready
  input  logic                 i_ready,
  // Corrected samples in
  adc_stream_if.sink           i_corr,
  // Averaged pair out
  output logic                 o_valid,
  output adc_pkg::adc_sample_t o_avg_a,
  output adc_pkg::adc_sample_t o_avg_b
);

  localparam int LOG2_DECIM = $clog2(DECIM);
  localparam int CNT_W      = (LOG2_DECIM > 0) ? LOG2_DECIM : 1;
  // Sum of DECIM samples needs log2(DECIM) extra bits
  localparam int ACC_W      = adc_pkg::ADC_BITS + LOG2_DECIM;

  logic signed [ACC_W-1:0] r_acc_a;
  logic signed [ACC_W-1:0] r_acc_b;
  logic [CNT_W-1:0]        r_cnt;
  logic                    r_valid;
  adc_pkg::adc_sample_t    r_avg_a;
  adc_pkg::adc_sample_t    r_avg_b;
  logic                    take;
  logic                    last;
  logic signed [ACC_W-1:0] sum_a;
  logic signed [ACC_W-1:0] sum_b;
  logic signed [ACC_W-1:0] mean_a;
  logic signed [ACC_W-1:0] mean_b;

  // No new input while an average waits downstream
  assign i_corr.ready = !r_valid;
  assign take         = i_corr.valid && i_corr.ready;
  assign last         = (r_cnt == CNT_W'(DECIM - 1));

  // Running sum including the pair on the input
  assign sum_a = r_acc_a + ACC_W'(i_corr.sample_a);
  assign sum_b = r_acc_b + ACC_W'(i_corr.sample_b);

  // Arithmetic shift divides by DECIM, rounding toward minus infinity
  assign mean_a = sum_a >>> LOG2_DECIM;
  assign mean_b = sum_b >>> LOG2_DECIM;

  assign o_valid = r_valid;
  assign o_avg_a = r_avg_a;
  assign o_avg_b = r_avg_b;

  // Group counter, accumulators and output valid
  always_ff @(negedge i_if_sclk) begin
    if (i_rst) begin
      r_acc_a <= '0;
      r_acc_b <= '0;
      r_cnt   <= '0;
      r_valid <= 1'b0;
    end else if (take) begin
      if (last) begin
        // Group complete, start the next one from zero
        r_acc_a <= '0;
        r_acc_b <= '0;
        r_cnt   <= '0;
        r_valid <= 1'b1;
      end else begin
        r_acc_a <= sum_a;
        r_acc_b <= sum_b;
        r_cnt   <= r_cnt + CNT_W'(1);
      end
    end else if (r_valid && i_ready) begin
      r_valid <= 1'b0;
    end
  end

  // Average pair, loaded only on the closing sample of a group
  always_ff @(negedge i_if_sclk) begin
    if (take && last) begin
      r_avg_a <= mean_a[adc_pkg::ADC_BITS-1:0];
      r_avg_b <= mean_b[adc_pkg::ADC_BITS-1:0];
    end
  end

endmodule

// ==== src/ad7357_sub.sv ====
`timescale 1ns/1ps

module ad7357_sub #(
  parameter int CONV_PERIOD = 24,
  parameter int DECIM       = 4
) (
  // ADC serial clock, also the clock of the whole block
  input  logic                 i_if_sclk,
  input  logic                 i_rst,
  // ADC pins
  input  logic                 i_if_sdata_a,
  input  logic                 i_if_sdata_b,
  output logic                 o_if_cs_n,
  // Static offset trim per channel
  input  adc_pkg::adc_sample_t i_offset_a,
  input  adc_pkg::adc_sample_t i_offset_b,
  // Averaged output stream
  input  logic                 i_ready,
  output logic                 o_valid,
  output adc_pkg::adc_sample_t o_avg_a,
  output adc_pkg::adc_sample_t o_avg_b
);

  logic conv_req;
  logic cap_idle;

  // Raw codes from capture, signed samples after correction
  adc_stream_if #(.SAMPLE_T(adc_pkg::adc_code_t))   raw_if ();
  adc_stream_if #(.SAMPLE_T(adc_pkg::adc_sample_t)) corr_if ();

  // Pacer waits on capture, so output stalls slow the sample rate
  conv_pacer #(
    .CONV_PERIOD (CONV_PERIOD)
  ) u_conv_pacer (
    .i_if_sclk  (i_if_sclk),
    .i_rst      (i_rst),
    .i_idle     (cap_idle),
    .o_conv_req (conv_req)
  );

  ad7357_capture u_ad7357_capture (
    .i_if_sclk    (i_if_sclk),
    .i_rst        (i_rst),
    .i_conv_req   (conv_req),
    .i_if_sdata_a (i_if_sdata_a),
    .i_if_sdata_b (i_if_sdata_b),
    .o_if_cs_n    (o_if_cs_n),
    .o_idle       (cap_idle),
    .o_raw        (raw_if.source)
  );

  offset_correct u_offset_correct (
    .i_if_sclk  (i_if_sclk),
    .i_rst      (i_rst),
    .i_offset_a (i_offset_a),
    .i_offset_b (i_offset_b),
    .i_raw      (raw_if.sink),
    .o_corr     (corr_if.source)
  );

  box_decimator #(
    .DECIM (DECIM)
  ) u_box_decimator (
    .i_if_sclk (i_if_sclk),
    .i_rst     (i_rst),
    .i_ready   (i_ready),
    .i_corr    (corr_if.sink),
    .o_valid   (o_valid),
    .o_avg_a   (o_avg_a),
    .o_avg_b   (o_avg_b)
  );

endmodule

// ==== dv/ad7357_checker.sv ====
`timescale 1ns/1ps

module ad7357_checker (
  input logic                 i_if_sclk,
  input logic                 i_rst,
  input logic                 i_cs_n,
  input logic                 i_valid,
  input logic                 i_ready,
  input adc_pkg::adc_sample_t i_avg_a,
  input adc_pkg::adc_sample_t i_avg_b
);

  // Chip select low for exactly one frame of 16 edges
  property p_frame_len;
    @(negedge i_if_sclk) disable iff (i_rst)
      $fell(i_cs_n) |-> (!i_cs_n) [*16] ##1 i_cs_n;
  endproperty

  // Output pair held until accepted
  property p_out_stable;
    @(negedge i_if_sclk) disable iff (i_rst)
      (i_valid && !i_ready) |=> (i_valid && $stable(i_avg_a) && $stable(i_avg_b));
  endproperty

  a_frame_len: assert property (p_frame_len)
    else $error("cs_n low period is not 16 edges");

  a_out_stable: assert property (p_out_stable)
    else $error("output changed while stalled");

endmodule

// ==== dv/tb_ad7357.sv ====
`timescale 1ns/1ps

module tb_ad7357;

  localparam int CONV_PERIOD = 24;
  localparam int DECIM       = 4;
  // Frames across all tests, with margin for stalls and aborted frames
  localparam int TOTAL_FRAMES = 240;
  // Worst-case edges from one frame start to the next
  localparam int FRAME_SPACING = CONV_PERIOD + adc_pkg::FRAME_EDGES;
  localparam int CYCLE_LIMIT = 40 * TOTAL_FRAMES * FRAME_SPACING;

  logic                 i_if_sclk;
  logic                 i_rst;
  logic                 i_if_sdata_a;
  logic                 i_if_sdata_b;
  adc_pkg::adc_sample_t i_offset_a;
  adc_pkg::adc_sample_t i_offset_b;
  logic                 i_ready;
  logic                 o_if_cs_n;
  logic                 o_valid;
  adc_pkg::adc_sample_t o_avg_a;
  adc_pkg::adc_sample_t o_avg_b;

  integer seed = 93;
  int     cycles;
  int     value_errs;
  int     other_errs;
  int     out_count;
  int     frame_count;
  // 0 random codes, 1 only full-scale extremes
  int     code_mode;
  // 0 held high, 1 random, 2 held low
  int     ready_mode;
  string  test_name;
  int     exp_a_q[$];
  int     exp_b_q[$];
  // Partial group of corrected samples
  int     grp_n;
  int     grp_a;
  int     grp_b;

  ad7357_sub #(
    .CONV_PERIOD (CONV_PERIOD),
    .DECIM       (DECIM)
  ) i_ad7357_sub (
    .i_if_sclk    (i_if_sclk),
    .i_rst        (i_rst),
    .i_if_sdata_a (i_if_sdata_a),
    .i_if_sdata_b (i_if_sdata_b),
    .o_if_cs_n    (o_if_cs_n),
    .i_offset_a   (i_offset_a),
    .i_offset_b   (i_offset_b),
    .i_ready      (i_ready),
    .o_valid      (o_valid),
    .o_avg_a      (o_avg_a),
    .o_avg_b      (o_avg_b)
  );

  bind ad7357_sub ad7357_checker u_checker (
    .i_if_sclk (i_if_sclk),
    .i_rst     (i_rst),
    .i_cs_n    (o_if_cs_n),
    .i_valid   (o_valid),
    .i_ready   (i_ready),
    .i_avg_a   (o_avg_a),
    .i_avg_b   (o_avg_b)
  );

  // Centered, offset removed, clipped to signed 14 bits
  function automatic int corrected(input int code, input int offset);
    int v;
    v = code - 8192 - offset;
    if (v > 8191) v = 8191;
    if (v < -8192) v = -8192;
    return v;
  endfunction

  // Group mean by arithmetic shift, log2 of 4
  function automatic int group_avg(input int sum);
    return sum >>> 2;
  endfunction

  initial begin
    i_if_sclk = 1'b0;
    forever #5 i_if_sclk = ~i_if_sclk;
  end

  // ADC serial model, one bit per falling edge while chip select is low
  initial begin : adc_model
    int   idx;
    logic [15:0] word_a;
    logic [15:0] word_b;
    int   ca;
    int   cb;
    idx = 0;
    word_a = '0;
    word_b = '0;
    forever begin
      @(negedge i_if_sclk);
      #1;
      if (o_if_cs_n) begin
        idx = 0;
        i_if_sdata_a = 1'b0;
        i_if_sdata_b = 1'b0;
      end else begin
        if (idx == 0) begin
          if (code_mode == 1) begin
            ca = ($random(seed) & 1) ? 16383 : 0;
            cb = ($random(seed) & 1) ? 16383 : 0;
          end else begin
            ca = $random(seed) & 16383;
            cb = $random(seed) & 16383;
          end
          // Two leading zeros, then the code
          word_a = 16'(ca);
          word_b = 16'(cb);
          frame_count++;
          grp_a += corrected(ca, int'(i_offset_a));
          grp_b += corrected(cb, int'(i_offset_b));
          grp_n++;
          if (grp_n == DECIM) begin
            exp_a_q.push_back(group_avg(grp_a));
            exp_b_q.push_back(group_avg(grp_b));
            grp_n = 0;
            grp_a = 0;
            grp_b = 0;
          end
        end
        if (idx < 16) begin
          i_if_sdata_a = word_a[15 - idx];
          i_if_sdata_b = word_b[15 - idx];
        end
        idx++;
      end
    end
  end

  // Ready pattern, changed away from the active edge
  always @(posedge i_if_sclk) begin
    #1;
    case (ready_mode)
      0: i_ready <= 1'b1;
      1: i_ready <= ($random(seed) % 3) != 0;
      default: i_ready <= 1'b0;
    endcase
  end

  // Output compare, a transfer happens on the next falling edge
  always @(posedge i_if_sclk) begin
    int ea;
    int eb;
    // Ready for the coming falling edge settles 1 ns after the rising edge
    #2;
    if (!i_rst && o_valid && i_ready) begin
      if (exp_a_q.size() == 0) begin
        $display("Output accepted in %s with no expected group left", test_name);
        other_errs++;
      end else begin
        ea = exp_a_q.pop_front();
        eb = exp_b_q.pop_front();
        assert (int'(o_avg_a) == ea) else begin
          $display("[FAIL] %s avg_a expected %0d actual %0d", test_name, ea, int'(o_avg_a));
          value_errs++;
        end
        assert (int'(o_avg_b) == eb) else begin
          $display("[FAIL] %s avg_b expected %0d actual %0d", test_name, eb, int'(o_avg_b));
          value_errs++;
        end
      end
      out_count++;
    end
  end

  // Run limit
  always @(posedge i_if_sclk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles in %s", cycles, test_name);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic apply_reset(input int off_a, input int off_b);
    @(posedge i_if_sclk);
    #1;
    i_rst      = 1'b1;
    i_offset_a = adc_pkg::adc_sample_t'(off_a);
    i_offset_b = adc_pkg::adc_sample_t'(off_b);
    repeat (4) @(posedge i_if_sclk);
    // Frame and group state of the model restarts with the DUT
    exp_a_q.delete();
    exp_b_q.delete();
    grp_n = 0;
    grp_a = 0;
    grp_b = 0;
    assert (o_if_cs_n && !o_valid) else begin
      $display("Chip select or output valid wrong during reset in %s", test_name);
      other_errs++;
    end
    #1;
    i_rst = 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    int target;
    target = out_count + n;
    while (out_count < target) @(posedge i_if_sclk);
  endtask

  initial begin
    int frames_mark;
    i_rst = 1'b1;
    i_if_sdata_a = 1'b0;
    i_if_sdata_b = 1'b0;
    i_offset_a = '0;
    i_offset_b = '0;
    i_ready = 1'b0;
    code_mode = 0;
    ready_mode = 0;
    test_name = "init";

    test_name = "zero_offset";
    apply_reset(0, 0);
    wait_outputs(16);

    test_name = "offset_shift";
    apply_reset(1000, -2500);
    wait_outputs(6);

    test_name = "saturation";
    code_mode = 1;
    apply_reset(4000, -4000);
    wait_outputs(6);
    code_mode = 0;

    test_name = "random_stall";
    ready_mode = 1;
    apply_reset(-300, 700);
    wait_outputs(16);

    test_name = "long_stall";
    ready_mode = 2;
    apply_reset(50, -50);
    repeat (200) @(posedge i_if_sclk);
    frames_mark = frame_count;
    repeat (200) @(posedge i_if_sclk);
    assert (frame_count == frames_mark) else begin
      $display("Frames kept running on cs_n while output was stalled");
      other_errs++;
    end
    ready_mode = 0;
    wait_outputs(4);

    test_name = "mid_frame_reset";
    wait (o_if_cs_n == 1'b0);
    repeat (5) @(posedge i_if_sclk);
    apply_reset(-20, 20);
    wait_outputs(4);
    // Groups already queued at the end must all come out
    while (exp_a_q.size() != 0) @(posedge i_if_sclk);
    ready_mode = 2;
    repeat (4) @(posedge i_if_sclk);

    $display("errors: value=%0d other=%0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/adc_pkg.sv
src/adc_stream_if.sv
src/conv_pacer.sv
src/ad7357_capture.sv
src/offset_correct.sv
src/box_decimator.sv
src/ad7357_sub.sv
dv/ad7357_checker.sv
dv/tb_ad7357.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_ad7357 \
  -f sim.f

./obj_dir/Vtb_ad7357 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
